/* common/xbar_pkg.sv */
// Memory crossbar shared definitions
// Widths and vector types for the client and memory sides of the crossbar
`default_nettype none

package xbar_pkg;

    // Memory word and byte address
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;

    // Client-local tag carried in the lower ID bits
    localparam int TAG_WIDTH = 5;

    // Client index in the upper ID bits, up to 8 clients
    localparam int CLIENT_IDX_WIDTH = 3;

    // Full ID as seen by the memory
    localparam int MEM_ID_WIDTH = CLIENT_IDX_WIDTH + TAG_WIDTH;

    typedef logic [ADDR_WIDTH-1:0]       addr_t;
    typedef logic [DATA_WIDTH-1:0]       data_t;
    typedef logic [TAG_WIDTH-1:0]        tag_t;
    typedef logic [CLIENT_IDX_WIDTH-1:0] client_idx_t;
    typedef logic [MEM_ID_WIDTH-1:0]     mem_id_t;

endpackage

`default_nettype wire

/* common/mem_port_if.sv */
// Single memory port
// One request channel and one response channel, both valid/ready
`default_nettype none

interface mem_port_if;
    import xbar_pkg::*;

    // Request channel
    logic    req_valid;
    logic    req_ready;
    logic    req_write;
    addr_t   req_addr;
    data_t   req_wdata;
    mem_id_t req_id;

    // Response channel, data is don't care for writes
    logic    resp_valid;
    logic    resp_ready;
    logic    resp_write;
    data_t   resp_data;
    mem_id_t resp_id;

    // Request side of the crossbar
    modport req_src (
        output req_valid, req_write, req_addr, req_wdata, req_id,
        input  req_ready
    );

    // Response side of the crossbar
    modport resp_sink (
        input  resp_valid, resp_write, resp_data, resp_id,
        output resp_ready
    );

    // Memory controller view
    modport mem (
        input  req_valid, req_write, req_addr, req_wdata, req_id,
        output req_ready,
        output resp_valid, resp_write, resp_data, resp_id,
        input  resp_ready
    );

endinterface

`default_nettype wire

/* hdl/xbar_arbiter.sv */
// Crossbar arbiter
// Round-robin grant with a limit on the number of requests in flight
`default_nettype none

module xbar_arbiter #(
    parameter int NUM_CLIENTS = 6,
    parameter int MAX_ISSUE   = 8
) (
    input  wire                    aclk,
    input  wire                    rst_n,
    input  wire  [NUM_CLIENTS-1:0] req_valid,
    input  wire                    slot_free,
    input  wire                    resp_done,
    output logic [NUM_CLIENTS-1:0] grant,
    output logic                   grant_valid
);
    import xbar_pkg::*;

    localparam int CNT_WIDTH = $clog2(MAX_ISSUE + 1);

    client_idx_t          rr_ptr;
    client_idx_t          pick_idx;
    logic                 pick_any;
    logic [CNT_WIDTH-1:0] outstanding;
    logic                 below_max;

    // Client index at a given distance after base, wrapping at NUM_CLIENTS
    function automatic client_idx_t rr_index(input client_idx_t base, input int offset);
        int sum;
        sum = int'(base) + offset;
        if (sum >= NUM_CLIENTS) begin
            sum = sum - NUM_CLIENTS;
        end
        return client_idx_t'(sum);
    endfunction

    // Walk backwards so the nearest requester at or after the pointer wins
    always_comb begin
        pick_idx = rr_ptr;
        pick_any = 1'b0;
        for (int i = NUM_CLIENTS - 1; i >= 0; i--) begin
            if (req_valid[rr_index(rr_ptr, i)]) begin
                pick_idx = rr_index(rr_ptr, i);
                pick_any = 1'b1;
            end
        end
    end

    assign below_max   = outstanding < CNT_WIDTH'(MAX_ISSUE);
    assign grant_valid = pick_any && slot_free && below_max;
    assign grant       = grant_valid ? (NUM_CLIENTS'(1) << pick_idx) : '0;

    // Next search starts after the client just granted
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr <= '0;
        end else if (grant_valid) begin
            rr_ptr <= rr_index(pick_idx, 1);
        end
    end

    // Requests in flight, accept and response in one cycle cancel out
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= '0;
        end else begin
            case ({grant_valid, resp_done})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/xbar_req_mux.sv */
// Crossbar request mux
// Picks the granted client, forms the memory ID and registers the request
`default_nettype none

module xbar_req_mux #(
    parameter int NUM_CLIENTS = 6
) (
    input  wire                                     aclk,
    input  wire                                     rst_n,
    input  wire  [NUM_CLIENTS-1:0]                  grant,
    input  wire                                     grant_valid,
    input  wire  [NUM_CLIENTS-1:0]                  cl_req_write,
    input  wire  xbar_pkg::addr_t [NUM_CLIENTS-1:0] cl_req_addr,
    input  wire  xbar_pkg::data_t [NUM_CLIENTS-1:0] cl_req_wdata,
    input  wire  xbar_pkg::tag_t  [NUM_CLIENTS-1:0] cl_req_tag,
    output logic [NUM_CLIENTS-1:0]                  cl_req_ready,
    output logic                                    slot_free,
    mem_port_if.req_src                             mem_port
);
    import xbar_pkg::*;

    client_idx_t grant_idx;
    logic        out_valid;
    logic        out_write;
    addr_t       out_addr;
    data_t       out_wdata;
    mem_id_t     out_id;

    // One-hot to index, the grant never has more than one bit set
    always_comb begin
        grant_idx = '0;
        for (int i = 0; i < NUM_CLIENTS; i++) begin
            if (grant[i]) begin
                grant_idx = grant_idx | client_idx_t'(i);
            end
        end
    end

    assign cl_req_ready = grant;
    assign slot_free    = !out_valid || mem_port.req_ready;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (grant_valid) begin
            out_valid <= 1'b1;
        end else if (mem_port.req_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Client index goes above the client's own tag
    always_ff @(posedge aclk) begin
        if (grant_valid) begin
            out_write <= cl_req_write[grant_idx];
            out_addr  <= cl_req_addr[grant_idx];
            out_wdata <= cl_req_wdata[grant_idx];
            out_id    <= {grant_idx, cl_req_tag[grant_idx]};
        end
    end

    assign mem_port.req_valid = out_valid;
    assign mem_port.req_write = out_write;
    assign mem_port.req_addr  = out_addr;
    assign mem_port.req_wdata = out_wdata;
    assign mem_port.req_id    = out_id;

endmodule

`default_nettype wire

/* hdl/xbar_resp_router.sv */
// Crossbar response router
// Steers each memory response to the client named in the upper ID bits
`default_nettype none

module xbar_resp_router #(
    parameter int NUM_CLIENTS = 6
) (
    input  wire  [NUM_CLIENTS-1:0]             cl_resp_ready,
    output logic [NUM_CLIENTS-1:0]             cl_resp_valid,
    output logic [NUM_CLIENTS-1:0]             cl_resp_write,
    output xbar_pkg::data_t [NUM_CLIENTS-1:0]  cl_resp_data,
    output xbar_pkg::tag_t  [NUM_CLIENTS-1:0]  cl_resp_tag,
    output logic                               resp_done,
    mem_port_if.resp_sink                      mem_port
);
    import xbar_pkg::*;

    client_idx_t target;
    tag_t        resp_tag;
    logic        target_ok;

    assign target    = mem_port.resp_id[MEM_ID_WIDTH-1 -: CLIENT_IDX_WIDTH];
    assign resp_tag  = mem_port.resp_id[TAG_WIDTH-1:0];
    assign target_ok = int'(target) < NUM_CLIENTS;

    // Only the valid is steered, payload fans out to every lane
    for (genvar i = 0; i < NUM_CLIENTS; i++) begin : g_lane
        assign cl_resp_valid[i] = mem_port.resp_valid && (target == client_idx_t'(i));
        assign cl_resp_write[i] = mem_port.resp_write;
        assign cl_resp_data[i]  = mem_port.resp_data;
        assign cl_resp_tag[i]   = resp_tag;
    end

    // A response for a client that does not exist is drained so the port never hangs
    assign mem_port.resp_ready = target_ok ? cl_resp_ready[target] : 1'b1;
    assign resp_done           = mem_port.resp_valid && mem_port.resp_ready;

endmodule

`default_nettype wire

/* hdl/mem_xbar.sv */
// Memory crossbar top level
// Shares one memory port between the render clients with round-robin arbitration
`default_nettype none

module mem_xbar #(
    parameter int NUM_CLIENTS = 6,
    parameter int MAX_ISSUE   = 8
) (
    input  wire                                        aclk,
    input  wire                                        rst_n,

    // Client request channel
    input  wire  [NUM_CLIENTS-1:0]                     cl_req_valid,
    output logic [NUM_CLIENTS-1:0]                     cl_req_ready,
    input  wire  [NUM_CLIENTS-1:0]                     cl_req_write,
    input  wire  xbar_pkg::addr_t [NUM_CLIENTS-1:0]    cl_req_addr,
    input  wire  xbar_pkg::data_t [NUM_CLIENTS-1:0]    cl_req_wdata,
    input  wire  xbar_pkg::tag_t  [NUM_CLIENTS-1:0]    cl_req_tag,

    // Client response channel
    output logic [NUM_CLIENTS-1:0]                     cl_resp_valid,
    input  wire  [NUM_CLIENTS-1:0]                     cl_resp_ready,
    output logic [NUM_CLIENTS-1:0]                     cl_resp_write,
    output xbar_pkg::data_t [NUM_CLIENTS-1:0]          cl_resp_data,
    output xbar_pkg::tag_t  [NUM_CLIENTS-1:0]          cl_resp_tag,

    // Memory request channel
    output logic                                       mem_req_valid,
    input  wire                                        mem_req_ready,
    output logic                                       mem_req_write,
    output xbar_pkg::addr_t                            mem_req_addr,
    output xbar_pkg::data_t                            mem_req_wdata,
    output xbar_pkg::mem_id_t                          mem_req_id,

    // Memory response channel
    input  wire                                        mem_resp_valid,
    output logic                                       mem_resp_ready,
    input  wire                                        mem_resp_write,
    input  wire  xbar_pkg::data_t                      mem_resp_data,
    input  wire  xbar_pkg::mem_id_t                    mem_resp_id
);

    logic [NUM_CLIENTS-1:0] grant;
    logic                   grant_valid;
    logic                   slot_free;
    logic                   resp_done;

    mem_port_if mem_if ();

    // Memory port pins
    assign mem_req_valid     = mem_if.req_valid;
    assign mem_req_write     = mem_if.req_write;
    assign mem_req_addr      = mem_if.req_addr;
    assign mem_req_wdata     = mem_if.req_wdata;
    assign mem_req_id        = mem_if.req_id;
    assign mem_if.req_ready  = mem_req_ready;
    assign mem_if.resp_valid = mem_resp_valid;
    assign mem_if.resp_write = mem_resp_write;
    assign mem_if.resp_data  = mem_resp_data;
    assign mem_if.resp_id    = mem_resp_id;
    assign mem_resp_ready    = mem_if.resp_ready;

    xbar_arbiter #(
        .NUM_CLIENTS (NUM_CLIENTS),
        .MAX_ISSUE   (MAX_ISSUE)
    ) arb_i (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .req_valid   (cl_req_valid),
        .slot_free   (slot_free),
        .resp_done   (resp_done),
        .grant       (grant),
        .grant_valid (grant_valid)
    );

    xbar_req_mux #(
        .NUM_CLIENTS (NUM_CLIENTS)
    ) req_mux_i (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .grant        (grant),
        .grant_valid  (grant_valid),
        .cl_req_write (cl_req_write),
        .cl_req_addr  (cl_req_addr),
        .cl_req_wdata (cl_req_wdata),
        .cl_req_tag   (cl_req_tag),
        .cl_req_ready (cl_req_ready),
        .slot_free    (slot_free),
        .mem_port     (mem_if.req_src)
    );

    xbar_resp_router #(
        .NUM_CLIENTS (NUM_CLIENTS)
    ) resp_router_i (
        .cl_resp_ready (cl_resp_ready),
        .cl_resp_valid (cl_resp_valid),
        .cl_resp_write (cl_resp_write),
        .cl_resp_data  (cl_resp_data),
        .cl_resp_tag   (cl_resp_tag),
        .resp_done     (resp_done),
        .mem_port      (mem_if.resp_sink)
    );

endmodule

`default_nettype wire

/* dv/mem_xbar_assertions.sv */
// Protocol assertions for the memory crossbar
// Request stability, single response target and the in-flight limit
`default_nettype none

module mem_xbar_assertions #(
    parameter int NUM_CLIENTS = 6,
    parameter int MAX_ISSUE   = 8,
    parameter int CNT_WIDTH   = $clog2(MAX_ISSUE + 1)
) (
    input wire                          aclk,
    input wire                          rst_n,
    input wire                          mem_req_valid,
    input wire                          mem_req_ready,
    input wire                          mem_req_write,
    input wire xbar_pkg::addr_t         mem_req_addr,
    input wire xbar_pkg::data_t         mem_req_wdata,
    input wire xbar_pkg::mem_id_t       mem_req_id,
    input wire [NUM_CLIENTS-1:0]        cl_resp_valid,
    input wire [CNT_WIDTH-1:0]          outstanding
);

    // Stalled memory request must not change
    req_stable_a : assert property (@(posedge aclk) disable iff (!rst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_write)
        && $stable(mem_req_addr) && $stable(mem_req_wdata) && $stable(mem_req_id))
        else $error("memory request changed while stalled");

    resp_onehot_a : assert property (@(posedge aclk) disable iff (!rst_n)
        $onehot0(cl_resp_valid))
        else $error("more than one client response valid");

    issue_limit_a : assert property (@(posedge aclk) disable iff (!rst_n)
        int'(outstanding) <= MAX_ISSUE)
        else $error("outstanding count above limit");

endmodule

bind mem_xbar mem_xbar_assertions #(
    .NUM_CLIENTS (NUM_CLIENTS),
    .MAX_ISSUE   (MAX_ISSUE)
) assertions_i (
    .aclk          (aclk),
    .rst_n         (rst_n),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_req_write (mem_req_write),
    .mem_req_addr  (mem_req_addr),
    .mem_req_wdata (mem_req_wdata),
    .mem_req_id    (mem_req_id),
    .cl_resp_valid (cl_resp_valid),
    .outstanding   (arb_i.outstanding)
);

`default_nettype wire

/* dv/mem_xbar_tb.sv */
// Memory crossbar testbench
// Table-driven client traffic against a randomized memory model
`default_nettype none

module mem_xbar_tb;
    import xbar_pkg::*;

    localparam int NC = 6;
    localparam int MAX_ISSUE = 8;
    localparam int NUM_ROWS = 24;
    localparam int ROW_BOUND = 40;
    localparam int CYCLE_LIMIT = NUM_ROWS * ROW_BOUND + 16;

    // Client, write flag, address, write data or expected read data, tag
    typedef struct packed {
        logic [2:0] client;
        logic       wr;
        addr_t      addr;
        data_t      data;
        tag_t       tag;
    } row_t;

    row_t tbl [NUM_ROWS] = '{
        '{3'd0, 1'b1, 32'h100, 32'hA000_0000, 5'd0},
        '{3'd1, 1'b1, 32'h104, 32'hA000_0001, 5'd1},
        '{3'd2, 1'b1, 32'h108, 32'hA000_0002, 5'd2},
        '{3'd3, 1'b1, 32'h10C, 32'hA000_0003, 5'd3},
        '{3'd4, 1'b1, 32'h110, 32'hA000_0004, 5'd4},
        '{3'd5, 1'b1, 32'h114, 32'hA000_0005, 5'd5},
        '{3'd0, 1'b0, 32'h114, 32'hA000_0005, 5'd6},
        '{3'd1, 1'b0, 32'h100, 32'hA000_0000, 5'd7},
        '{3'd2, 1'b0, 32'h104, 32'hA000_0001, 5'd8},
        '{3'd3, 1'b0, 32'h108, 32'hA000_0002, 5'd9},
        '{3'd4, 1'b0, 32'h10C, 32'hA000_0003, 5'd10},
        '{3'd5, 1'b0, 32'h110, 32'hA000_0004, 5'd11},
        '{3'd0, 1'b1, 32'h200, 32'hB000_0000, 5'd12},
        '{3'd1, 1'b1, 32'h204, 32'hB000_0001, 5'd13},
        '{3'd2, 1'b1, 32'h208, 32'hB000_0002, 5'd14},
        '{3'd3, 1'b1, 32'h20C, 32'hB000_0003, 5'd15},
        '{3'd4, 1'b1, 32'h210, 32'hB000_0004, 5'd16},
        '{3'd5, 1'b1, 32'h214, 32'hB000_0005, 5'd17},
        '{3'd0, 1'b0, 32'h204, 32'hB000_0001, 5'd18},
        '{3'd1, 1'b0, 32'h208, 32'hB000_0002, 5'd19},
        '{3'd2, 1'b0, 32'h20C, 32'hB000_0003, 5'd20},
        '{3'd3, 1'b0, 32'h210, 32'hB000_0004, 5'd21},
        '{3'd4, 1'b0, 32'h214, 32'hB000_0005, 5'd22},
        '{3'd5, 1'b0, 32'h200, 32'hB000_0000, 5'd23}
    };

    logic aclk;
    logic rst_n;
    logic [NC-1:0] cl_req_valid, cl_req_ready, cl_req_write;
    addr_t [NC-1:0] cl_req_addr;
    data_t [NC-1:0] cl_req_wdata;
    tag_t [NC-1:0] cl_req_tag;
    logic [NC-1:0] cl_resp_valid, cl_resp_ready, cl_resp_write;
    data_t [NC-1:0] cl_resp_data;
    tag_t [NC-1:0] cl_resp_tag;
    logic mem_req_valid, mem_req_ready, mem_req_write;
    addr_t mem_req_addr;
    data_t mem_req_wdata;
    mem_id_t mem_req_id;
    logic mem_resp_valid, mem_resp_ready, mem_resp_write;
    data_t mem_resp_data;
    mem_id_t mem_resp_id;

    // Memory model and bookkeeping
    data_t mem [addr_t];
    mem_id_t rq_id [$];
    logic rq_wr [$];
    data_t rq_data [$];
    int pend [NC][$];
    int issue_q [$];
    logic [NC-1:0] acc;
    int resp_idx;
    logic resp_active;
    logic hold_resp;
    logic traffic_on;
    int ready_mode;
    int issued, done, cycles, base;
    logic [72:0] snap;

    mem_xbar #(.NUM_CLIENTS(NC), .MAX_ISSUE(MAX_ISSUE)) dut_i (.*);

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    task automatic report_fail(input string line);
        $display("%s", line);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped on error");
    endtask

    function automatic int find_row(input int c, input tag_t t);
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (int'(tbl[i].client) == c && tbl[i].tag == t) return i;
        end
        return -1;
    endfunction

    task automatic load_rows(input int first, input int last);
        for (int i = first; i <= last; i++) begin
            pend[tbl[i].client].push_back(i);
        end
    endtask

    // Monitor and memory model, sampled on the rising edge
    always @(posedge aclk) begin
        int c;
        int k;
        cycles++;
        if (cycles > CYCLE_LIMIT) report_fail($sformatf("Timeout after %0d cycles", cycles));
        acc = rst_n ? (cl_req_valid & cl_req_ready) : '0;
        if (rst_n && mem_req_valid && mem_req_ready) begin
            c = int'(mem_req_id[7:5]);
            k = find_row(c, mem_req_id[4:0]);
            assert (k >= 0) else report_fail("No table row matches the memory request ID");
            assert (mem_req_addr == tbl[k].addr && mem_req_write == tbl[k].wr
                    && mem_req_wdata == tbl[k].data)
                else report_fail($sformatf("FAIL at %0t: request fields of row %0d", $time, k));
            if (mem_req_write) mem[mem_req_addr] = mem_req_wdata;
            rq_id.push_back(mem_req_id);
            rq_wr.push_back(mem_req_write);
            rq_data.push_back(mem.exists(mem_req_addr) ? mem[mem_req_addr] : 32'hDEAD_BEEF);
            issue_q.push_back(c);
            issued++;
        end
        if (rst_n && mem_resp_valid) begin
            c = int'(mem_resp_id[7:5]);
            k = find_row(c, mem_resp_id[4:0]);
            // Only the named client sees the response, and its ready goes back to memory
            assert (cl_resp_valid == (NC'(1) << c) && mem_resp_ready == cl_resp_ready[c])
                else report_fail($sformatf("FAIL at %0t: routing for row %0d", $time, k));
            if (mem_resp_ready) begin
                assert (cl_resp_tag[c] == tbl[k].tag && cl_resp_write[c] == tbl[k].wr
                        && (tbl[k].wr || cl_resp_data[c] == tbl[k].data))
                    else report_fail($sformatf("FAIL at %0t: response for row %0d", $time, k));
                rq_id.delete(resp_idx);
                rq_wr.delete(resp_idx);
                rq_data.delete(resp_idx);
                resp_active = 1'b0;
                done++;
            end
        end
    end

    // Client, memory ready and response drivers on the falling edge
    always @(negedge aclk) begin
        int k;
        if (traffic_on) begin
            for (int c = 0; c < NC; c++) begin
                if (acc[c]) cl_req_valid[c] = 1'b0;
                if (!cl_req_valid[c] && pend[c].size() > 0) begin
                    k = pend[c].pop_front();
                    cl_req_write[c] = tbl[k].wr;
                    cl_req_addr[c]  = tbl[k].addr;
                    cl_req_wdata[c] = tbl[k].data;
                    cl_req_tag[c]   = tbl[k].tag;
                    cl_req_valid[c] = 1'b1;
                end
            end
            mem_req_ready = (ready_mode == 0) ? 1'b1 :
                            (ready_mode == 1) ? 1'($urandom % 2) : 1'b0;
            cl_resp_ready = NC'($urandom) | NC'($urandom);
            if (!resp_active) mem_resp_valid = 1'b0;
            // Random delay and random order among queued responses
            if (!resp_active && !hold_resp && rq_id.size() > 0 && ($urandom % 2) == 0) begin
                resp_idx = int'($urandom % rq_id.size());
                mem_resp_id    = rq_id[resp_idx];
                mem_resp_write = rq_wr[resp_idx];
                mem_resp_data  = rq_data[resp_idx];
                mem_resp_valid = 1'b1;
                resp_active    = 1'b1;
            end
        end
    end

    initial begin
        void'($urandom(42363));
        {cl_req_valid, cl_req_write, cl_req_addr, cl_req_wdata, cl_req_tag} = '0;
        {cl_resp_ready, mem_req_ready, mem_resp_valid, mem_resp_write} = '0;
        {mem_resp_data, mem_resp_id, acc, resp_active, hold_resp, traffic_on} = '0;
        {ready_mode, issued, done, cycles, resp_idx} = '0;
        rst_n = 1'b0;
        repeat (16) @(negedge aclk);
        rst_n = 1'b1;
        @(posedge aclk);
        assert (!mem_req_valid && cl_req_ready == '0 && cl_resp_valid == '0)
            else report_fail($sformatf("FAIL at %0t: outputs not idle after reset", $time));
        traffic_on = 1'b1;

        // All six clients at once, order must be 0 to 5
        load_rows(0, 5);
        while (done < 6) @(negedge aclk);
        for (int i = 0; i < NC; i++) begin
            assert (issue_q[i] == i)
                else report_fail($sformatf("FAIL at %0t: grant order slot %0d", $time, i));
        end

        // No responses, only MAX_ISSUE requests may reach the memory
        base = issued;
        @(posedge aclk);
        hold_resp = 1'b1;
        load_rows(6, 17);
        while (issued < base + MAX_ISSUE) @(negedge aclk);
        repeat (20) @(negedge aclk);
        assert (issued == base + MAX_ISSUE)
            else report_fail($sformatf("FAIL at %0t: %0d requests issued", $time, issued - base));
        @(posedge aclk);
        hold_resp = 1'b0;
        while (done < 18) @(negedge aclk);

        // Memory stalls, request must hold and no client is accepted
        @(posedge aclk);
        ready_mode = 2;
        load_rows(18, 23);
        while (!mem_req_valid) @(negedge aclk);
        snap = {mem_req_write, mem_req_addr, mem_req_wdata, mem_req_id};
        repeat (10) begin
            @(posedge aclk);
            assert (mem_req_valid && cl_req_ready == '0 && snap ==
                    {mem_req_write, mem_req_addr, mem_req_wdata, mem_req_id})
                else report_fail($sformatf("FAIL at %0t: stalled request changed", $time));
        end
        ready_mode = 1;
        while (done < NUM_ROWS) @(negedge aclk);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
common/xbar_pkg.sv
common/mem_port_if.sv
hdl/xbar_arbiter.sv
hdl/xbar_req_mux.sv
hdl/xbar_resp_router.sv
hdl/mem_xbar.sv
dv/mem_xbar_assertions.sv
dv/mem_xbar_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f flist.f --top-module mem_xbar_tb -o mem_xbar_sim
	./obj_dir/mem_xbar_sim > sim.log 2>&1; cat sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
